/* verilog/mipsCore_cfg.svh */
`ifndef MIPS_CORE_CFG_SVH
`define MIPS_CORE_CFG_SVH

// datapath and register file sizes
`define MIPS_XLEN       32
`define MIPS_REG_BITS   5
`define MIPS_NUM_REGS   32
`define MIPS_DADDR_BITS 7
`define MIPS_LINK_REG   5'd31

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct field of R-type
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_JR  6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`endif

/* verilog/mipsPkg.sv */
`include "mipsCore_cfg.svh"

package mipsPkg;

    // R view
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`MIPS_REG_BITS-1:0] rs;
        logic [`MIPS_REG_BITS-1:0] rt;
        logic [`MIPS_REG_BITS-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } rFields_t;

    // I view
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`MIPS_REG_BITS-1:0] rs;
        logic [`MIPS_REG_BITS-1:0] rt;
        logic [15:0]                imm;
    } iFields_t;

    // J view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFields_t;

    // one instruction word, three decodings
    typedef union packed {
        rFields_t r;
        iFields_t i;
        jFields_t j;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6
    } aluOp_e;

    // where the register write data comes from
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wbSrc_e;

endpackage

/* verilog/decodeIf.sv */
`timescale 1ns/1ns
`include "mipsCore_cfg.svh"

interface decodeIf;
    mipsPkg::aluOp_e            aluOp;
    logic                       aluSrcImm;
    logic                       regWrite;
    mipsPkg::wbSrc_e            wbSrc;
    logic [`MIPS_REG_BITS-1:0] destReg;
    logic                       branch;
    logic                       branchNe;
    logic                       jump;
    logic                       jumpReg;
    logic                       memRead;
    logic                       memWrite;

    modport dec (
        output aluOp, aluSrcImm, regWrite, wbSrc, destReg,
        output branch, branchNe, jump, jumpReg, memRead, memWrite
    );

    // ALU and branch compare
    modport exe (
        input aluOp, aluSrcImm, branch, branchNe
    );

    // write-back and next PC
    modport res (
        input regWrite, wbSrc, destReg, jump, jumpReg
    );
endinterface

/* verilog/instrDecode.sv */
`timescale 1ns/1ns
`include "mipsCore_cfg.svh"

module instrDecode (
    input  mipsPkg::instr_t instr,
    decodeIf.dec            ctl
);

    always_comb begin
        // no-op unless the opcode says otherwise
        ctl.aluOp     = mipsPkg::ALU_ADD;
        ctl.aluSrcImm = 1'b0;
        ctl.regWrite  = 1'b0;
        ctl.wbSrc     = mipsPkg::WB_ALU;
        ctl.destReg   = '0;
        ctl.branch    = 1'b0;
        ctl.branchNe  = 1'b0;
        ctl.jump      = 1'b0;
        ctl.jumpReg   = 1'b0;
        ctl.memRead   = 1'b0;
        ctl.memWrite  = 1'b0;

        case (instr.r.opcode)
            `OP_RTYPE: begin
                ctl.destReg  = instr.r.rd;
                ctl.regWrite = 1'b1;
                case (instr.r.funct)
                    `FN_ADD: ctl.aluOp = mipsPkg::ALU_ADD;
                    `FN_SUB: ctl.aluOp = mipsPkg::ALU_SUB;
                    `FN_AND: ctl.aluOp = mipsPkg::ALU_AND;
                    `FN_OR:  ctl.aluOp = mipsPkg::ALU_OR;
                    `FN_SLT: ctl.aluOp = mipsPkg::ALU_SLT;
                    `FN_SLL: ctl.aluOp = mipsPkg::ALU_SLL;
                    `FN_SRL: ctl.aluOp = mipsPkg::ALU_SRL;
                    `FN_JR: begin
                        ctl.regWrite = 1'b0;
                        ctl.jumpReg  = 1'b1;
                    end
                    // unknown funct writes nothing
                    default: ctl.regWrite = 1'b0;
                endcase
            end
            `OP_ADDI: begin
                ctl.aluSrcImm = 1'b1;
                ctl.regWrite  = 1'b1;
                ctl.destReg   = instr.i.rt;
            end
            `OP_LW: begin
                ctl.aluSrcImm = 1'b1;
                ctl.regWrite  = 1'b1;
                ctl.wbSrc     = mipsPkg::WB_MEM;
                ctl.destReg   = instr.i.rt;
                ctl.memRead   = 1'b1;
            end
            `OP_SW: begin
                ctl.aluSrcImm = 1'b1;
                ctl.memWrite  = 1'b1;
            end
            `OP_BEQ: begin
                ctl.aluOp  = mipsPkg::ALU_SUB;
                ctl.branch = 1'b1;
            end
            `OP_BNE: begin
                ctl.aluOp    = mipsPkg::ALU_SUB;
                ctl.branchNe = 1'b1;
            end
            `OP_J: begin
                ctl.jump = 1'b1;
            end
            `OP_JAL: begin
                ctl.jump     = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.wbSrc    = mipsPkg::WB_LINK;
                ctl.destReg  = `MIPS_LINK_REG;
            end
            default: begin
                ctl.regWrite = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ns
`include "mipsCore_cfg.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`MIPS_REG_BITS-1:0] rsAddr,
    input  logic [`MIPS_REG_BITS-1:0] rtAddr,
    input  logic                       wrEn,
    input  logic [`MIPS_REG_BITS-1:0] wrAddr,
    input  logic [`MIPS_XLEN-1:0]     wrData,
    output logic [`MIPS_XLEN-1:0]     rsData,
    output logic [`MIPS_XLEN-1:0]     rtData
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            // r0 is never written so it stays zero
            regs[wrAddr] <= wrData;
        end
    end

    // combinational read ports
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

/* verilog/aluExecute.sv */
`timescale 1ns/1ns
`include "mipsCore_cfg.svh"

module aluExecute (
    decodeIf.exe                    ctl,
    input  mipsPkg::instr_t         instr,
    input  logic [`MIPS_XLEN-1:0]  rsData,
    input  logic [`MIPS_XLEN-1:0]  rtData,
    output logic [`MIPS_XLEN-1:0]  aluResult,
    output logic                    branchTaken
);

    logic [`MIPS_XLEN-1:0] signImm;
    logic [`MIPS_XLEN-1:0] opB;
    logic                   operandsEqual;

    assign signImm = {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
    assign opB     = ctl.aluSrcImm ? signImm : rtData;

    always_comb begin
        case (ctl.aluOp)
            mipsPkg::ALU_ADD: aluResult = rsData + opB;
            mipsPkg::ALU_SUB: aluResult = rsData - opB;
            mipsPkg::ALU_AND: aluResult = rsData & opB;
            mipsPkg::ALU_OR:  aluResult = rsData | opB;
            mipsPkg::ALU_SLT: begin
                aluResult = ($signed(rsData) < $signed(opB)) ? 'd1 : '0;
            end
            // shifts take rt and the shamt field
            mipsPkg::ALU_SLL: aluResult = rtData << instr.r.shamt;
            mipsPkg::ALU_SRL: aluResult = rtData >> instr.r.shamt;
            default:          aluResult = '0;
        endcase
    end

    // branch compare always on the two register operands
    assign operandsEqual = (rsData == rtData);
    assign branchTaken   = (ctl.branch & operandsEqual) | (ctl.branchNe & ~operandsEqual);

endmodule

/* verilog/resultSelect.sv */
`timescale 1ns/1ns
`include "mipsCore_cfg.svh"

module resultSelect (
    input  logic                       clk,
    input  logic                       rst_n,
    decodeIf.res                       ctl,
    input  mipsPkg::instr_t            instr,
    input  logic [`MIPS_XLEN-1:0]     rsData,
    input  logic [`MIPS_XLEN-1:0]     aluResult,
    input  logic                       branchTaken,
    input  logic [`MIPS_XLEN-1:0]     memRdata,
    output logic                       wrEn,
    output logic [`MIPS_REG_BITS-1:0] wrAddr,
    output logic [`MIPS_XLEN-1:0]     wrData,
    output logic [`MIPS_XLEN-1:0]     pc
);

    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] branchOffset;
    logic [`MIPS_XLEN-1:0] nextPc;

    assign pcPlus4      = pc + 'd4;
    assign branchOffset = {{(`MIPS_XLEN-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};

    // write-back
    assign wrEn   = ctl.regWrite;
    assign wrAddr = ctl.destReg;

    always_comb begin
        case (ctl.wbSrc)
            mipsPkg::WB_MEM:  wrData = memRdata;
            mipsPkg::WB_LINK: wrData = pcPlus4;
            default:          wrData = aluResult;
        endcase
    end

    // jr wins over j/jal, then taken branch
    always_comb begin
        if (ctl.jumpReg) begin
            nextPc = rsData;
        end else if (ctl.jump) begin
            nextPc = {pcPlus4[31:28], instr.j.target, 2'b00};
        end else if (branchTaken) begin
            nextPc = pcPlus4 + branchOffset;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* verilog/mipsCore.sv */
`timescale 1ns/1ns
`include "mipsCore_cfg.svh"

module mipsCore (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`MIPS_XLEN-1:0]        instr,
    output logic [`MIPS_XLEN-1:0]        instrAddr,
    input  logic [`MIPS_XLEN-1:0]        memRdata,
    output logic                          memCeN,
    output logic                          memWeN,
    output logic                          memOeN,
    output logic [`MIPS_DADDR_BITS-1:0]  memAddr,
    output logic [`MIPS_XLEN-1:0]        memWdata
);

    mipsPkg::instr_t            instrWord;
    logic [`MIPS_XLEN-1:0]     rsData;
    logic [`MIPS_XLEN-1:0]     rtData;
    logic [`MIPS_XLEN-1:0]     aluResult;
    logic                       branchTaken;
    logic                       wrEn;
    logic [`MIPS_REG_BITS-1:0] wrAddr;
    logic [`MIPS_XLEN-1:0]     wrData;

    assign instrWord = instr;

    decodeIf ctlBus ();

    instrDecode i_instrDecode (
        .instr (instrWord),
        .ctl   (ctlBus)
    );

    regFile i_regFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rsAddr (instrWord.r.rs),
        .rtAddr (instrWord.r.rt),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rsData (rsData),
        .rtData (rtData)
    );

    aluExecute i_aluExecute (
        .ctl         (ctlBus),
        .instr       (instrWord),
        .rsData      (rsData),
        .rtData      (rtData),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    resultSelect i_resultSelect (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctl         (ctlBus),
        .instr       (instrWord),
        .rsData      (rsData),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .memRdata    (memRdata),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .pc          (instrAddr)
    );

    // data memory strobes are active low
    assign memCeN   = ~(ctlBus.memRead | ctlBus.memWrite);
    assign memWeN   = ~ctlBus.memWrite;
    assign memOeN   = ctlBus.memWrite;
    // word address from the byte address
    assign memAddr  = aluResult[`MIPS_DADDR_BITS+1:2];
    assign memWdata = rtData;

endmodule

/* testbench/tbMipsModel.svh */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// architectural state that the reference steps through
typedef struct packed {
    logic [31:0]        pc;
    logic [31:0][31:0]  regs;
    logic [127:0][31:0] mem;
} modelState_t;

// effects of one instruction
typedef struct packed {
    logic [31:0] nextPc;
    logic        regWe;
    logic [4:0]  regAddr;
    logic [31:0] regData;
    logic        memWe;
    logic        memRe;
    logic [6:0]  memAddr;
    logic [31:0] memData;
} stepResult_t;

// start-up data word from the whole word address
function automatic logic [31:0] fillWord(input logic [6:0] addr);
    return {16'hd00d, 2'b00, addr, ~addr};
endfunction

function automatic stepResult_t stepModel(input modelState_t st, input logic [31:0] ins);
    stepResult_t r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] pc4;
    logic [31:0] ea;
    a    = st.regs[ins[25:21]];
    b    = st.regs[ins[20:16]];
    simm = {{16{ins[15]}}, ins[15:0]};
    pc4  = st.pc + 32'd4;
    ea   = a + simm;
    r    = '0;
    r.nextPc = pc4;
    case (ins[31:26])
        `OP_RTYPE: begin
            r.regWe   = 1'b1;
            r.regAddr = ins[15:11];
            case (ins[5:0])
                `FN_ADD: r.regData = a + b;
                `FN_SUB: r.regData = a - b;
                `FN_AND: r.regData = a & b;
                `FN_OR:  r.regData = a | b;
                `FN_SLT: r.regData = {31'd0, $signed(a) < $signed(b)};
                `FN_SLL: r.regData = b << ins[10:6];
                `FN_SRL: r.regData = b >> ins[10:6];
                `FN_JR: begin
                    r.regWe  = 1'b0;
                    r.nextPc = a;
                end
                default: r.regWe = 1'b0;
            endcase
        end
        `OP_ADDI, `OP_LW: begin
            r.regWe   = 1'b1;
            r.regAddr = ins[20:16];
            r.memRe   = (ins[31:26] == `OP_LW);
            r.regData = (ins[31:26] == `OP_LW) ? st.mem[ea[8:2]] : ea;
        end
        `OP_SW: begin
            r.memWe   = 1'b1;
            r.memAddr = ea[8:2];
            r.memData = b;
        end
        `OP_BEQ: if (a == b) r.nextPc = pc4 + {simm[29:0], 2'b00};
        `OP_BNE: if (a != b) r.nextPc = pc4 + {simm[29:0], 2'b00};
        `OP_J:   r.nextPc = {pc4[31:28], ins[25:0], 2'b00};
        `OP_JAL: begin
            r.nextPc  = {pc4[31:28], ins[25:0], 2'b00};
            r.regWe   = 1'b1;
            r.regAddr = `MIPS_LINK_REG;
            r.regData = pc4;
        end
        default: ;
    endcase
    // r0 holds zero
    if (r.regAddr == 5'd0) r.regWe = 1'b0;
    return r;
endfunction

function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] sh);
    return {`OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encJ(input logic [5:0] op, input int wordIdx);
    logic [31:0] w;
    w = 32'(wordIdx);
    return {op, w[25:0]};
endfunction

// offset field for a branch at word fromIdx to word toIdx
function automatic logic [15:0] branchOff(input int fromIdx, input int toIdx);
    int d;
    d = toIdx - fromIdx - 1;
    return d[15:0];
endfunction

task automatic emit(input logic [31:0] word);
    imem[progLen[7:0]] = word;
    progLen++;
endtask

task automatic buildProgram();
    logic [5:0]  fns [8];
    logic [15:0] immA;
    logic [15:0] immB;
    logic [4:0]  sh;
    int          mark;
    fns  = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLT, `FN_SLL, `FN_SRL};
    immA = 16'($urandom()) | 16'h0001;
    immB = 16'($urandom());
    sh   = 5'($urandom());
    progLen = 0;
    // random operands and one stored word per result
    emit(encI(`OP_ADDI, 5'd1, 5'd0, immA));
    emit(encI(`OP_ADDI, 5'd2, 5'd0, immB));
    for (int k = 0; k < 8; k++) begin
        emit(encR(fns[k], 5'd3, (k == 5) ? 5'd2 : 5'd1, (k == 5) ? 5'd1 : 5'd2, sh));
        emit(encI(`OP_SW, 5'd3, 5'd0, 16'(k * 4)));
    end
    // store, load back into other registers, store again
    emit(encI(`OP_ADDI, 5'd4, 5'd0, 16'($urandom())));
    emit(encI(`OP_SW, 5'd4, 5'd0, 16'd64));
    emit(encI(`OP_SW, 5'd1, 5'd0, 16'd68));
    emit(encI(`OP_LW, 5'd5, 5'd0, 16'd64));
    emit(encI(`OP_LW, 5'd6, 5'd0, 16'd68));
    emit(encI(`OP_LW, 5'd7, 5'd0, 16'd200));
    emit(encI(`OP_SW, 5'd5, 5'd0, 16'd72));
    emit(encI(`OP_SW, 5'd6, 5'd0, 16'd76));
    emit(encI(`OP_SW, 5'd7, 5'd0, 16'd80));
    // count-down loop closed by a backward bne
    emit(encI(`OP_ADDI, 5'd8, 5'd0, 16'd3));
    mark = progLen;
    emit(encI(`OP_ADDI, 5'd8, 5'd8, 16'hffff));
    emit(encI(`OP_BNE, 5'd0, 5'd8, branchOff(progLen, mark)));
    // forward beq taken, then beq and bne not taken
    emit(encI(`OP_BEQ, 5'd0, 5'd8, branchOff(progLen, progLen + 2)));
    emit(encI(`OP_ADDI, 5'd9, 5'd0, 16'd1));
    emit(encI(`OP_BEQ, 5'd1, 5'd8, branchOff(progLen, progLen + 2)));
    emit(encI(`OP_ADDI, 5'd9, 5'd9, 16'd2));
    emit(encI(`OP_BNE, 5'd0, 5'd8, branchOff(progLen, progLen + 2)));
    emit(encI(`OP_ADDI, 5'd9, 5'd9, 16'd4));
    emit(encI(`OP_SW, 5'd9, 5'd0, 16'd84));
    // j over a routine, jal into it, jr r31 back
    mark = progLen;
    emit(encJ(`OP_J, mark + 4));
    emit(encI(`OP_ADDI, 5'd10, 5'd0, 16'd7));
    emit(encI(`OP_ADDI, 5'd11, 5'd0, 16'h0055));
    emit(encR(`FN_JR, 5'd0, 5'd31, 5'd0, 5'd0));
    jalPc = progLen * 4;
    emit(encJ(`OP_JAL, mark + 2));
    emit(encI(`OP_SW, 5'd31, 5'd0, 16'd88));
    emit(encI(`OP_SW, 5'd11, 5'd0, 16'd92));
    emit(encI(`OP_SW, 5'd10, 5'd0, 16'd96));
    // codes outside the kept set including swc1
    emit(encR(6'h3f, 5'd12, 5'd1, 5'd2, 5'd0));
    emit(encI(6'h0f, 5'd12, 5'd0, 16'hbeef));
    emit(encI(6'h39, 5'd1, 5'd0, 16'd100));
    emit({6'h3f, 26'($urandom())});
    emit(encI(`OP_SW, 5'd12, 5'd0, 16'd100));
    // final self loop
    emit(encI(`OP_BEQ, 5'd0, 5'd0, 16'hffff));
endtask

`endif

/* testbench/tbMipsCore.sv */
`timescale 1ns/1ns
`include "mipsCore_cfg.svh"

module tbMipsCore;

    logic                        clk;
    logic                        rst_n;
    logic [`MIPS_XLEN-1:0]       instr;
    logic [`MIPS_XLEN-1:0]       instrAddr;
    logic [`MIPS_XLEN-1:0]       memRdata;
    logic                        memCeN;
    logic                        memWeN;
    logic                        memOeN;
    logic [`MIPS_DADDR_BITS-1:0] memAddr;
    logic [`MIPS_XLEN-1:0]       memWdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [128];
    int          progLen;
    int          jalPc;
    int          errCount;
    int          cycleCount;
    int          cycleLimit;
    logic        done;

    `include "tbMipsModel.svh"

    modelState_t model;
    stepResult_t step;

    mipsCore i_mipsCore (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .instrAddr (instrAddr),
        .memRdata  (memRdata),
        .memCeN    (memCeN),
        .memWeN    (memWeN),
        .memOeN    (memOeN),
        .memAddr   (memAddr),
        .memWdata  (memWdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // both memories read without a clock
    assign instr    = imem[instrAddr[9:2]];
    assign memRdata = (!memCeN && !memOeN) ? dmem[memAddr] : 32'd0;

    always @(posedge clk) begin
        if (!memCeN && !memWeN) begin
            dmem[memAddr] <= memWdata;
        end
    end

    task automatic flagMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        errCount++;
    endtask

    // reference steps once per edge against the DUT outputs just before it
    always @(posedge clk) begin
        if (!rst_n) begin
            model.pc   = '0;
            model.regs = '0;
            for (int a = 0; a < 128; a++) begin
                model.mem[a[6:0]] = fillWord(a[6:0]);
            end
            done       = 1'b0;
            cycleCount = 0;
            assert (instrAddr == 32'd0)
                else flagMismatch("instrAddr in reset", instrAddr, 32'd0);
        end else if (!done) begin
            cycleCount++;
            step = stepModel(model, imem[model.pc[9:2]]);
            assert (instrAddr == model.pc)
                else flagMismatch("instrAddr", instrAddr, model.pc);
            assert (memCeN == !(step.memWe || step.memRe))
                else flagMismatch("memCeN", 32'(memCeN), 32'(!(step.memWe || step.memRe)));
            assert (memWeN == !step.memWe)
                else flagMismatch("memWeN", 32'(memWeN), 32'(!step.memWe));
            assert (memOeN == step.memWe)
                else flagMismatch("memOeN", 32'(memOeN), 32'(step.memWe));
            if (step.memWe) begin
                assert (memAddr == step.memAddr)
                    else flagMismatch("memAddr", 32'(memAddr), 32'(step.memAddr));
                assert (memWdata == step.memData)
                    else flagMismatch("memWdata", memWdata, step.memData);
            end
            if (step.regWe) model.regs[step.regAddr] = step.regData;
            if (step.memWe) model.mem[step.memAddr] = step.memData;
            // a branch onto itself ends the program
            done     = (step.nextPc == model.pc);
            model.pc = step.nextPc;
        end
    end

    initial begin
        void'($urandom(32'h33a8_3d24));
        errCount = 0;
        for (int a = 0; a < 256; a++) begin
            imem[a[7:0]] = 32'd0;
        end
        for (int a = 0; a < 128; a++) begin
            dmem[a[6:0]] = fillWord(a[6:0]);
        end
        buildProgram();
        cycleLimit = 2 * progLen + 50;
        rst_n = 1'b1;
        // falling edge so the asynchronous clear fires
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!done && cycleCount < cycleLimit) begin
            @(negedge clk);
        end
        if (!done) begin
            $display("timeout: program did not reach its final loop in %0d cycles", cycleLimit);
            errCount++;
        end
        for (int a = 0; a < 128; a++) begin
            assert (dmem[a[6:0]] == model.mem[a[6:0]])
                else flagMismatch($sformatf("data word %0d", a), dmem[a[6:0]],
                                  model.mem[a[6:0]]);
        end
        // link value saved by the jal section
        assert (dmem[7'd22] == 32'(jalPc + 4))
            else flagMismatch("stored r31", dmem[7'd22], 32'(jalPc + 4));
        $display("summary: %0d errors", errCount);
        if (errCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* mipsCore.f */
+incdir+verilog
+incdir+testbench
verilog/mipsPkg.sv
verilog/decodeIf.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/aluExecute.sv
verilog/resultSelect.sv
verilog/mipsCore.sv
testbench/tbMipsCore.sv

/* runSim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tbMipsCore \
    -f mipsCore.f \
    -o simMipsCore

simOutput="$(./obj_dir/simMipsCore)"
echo "$simOutput"

if grep -qF '** PASS **' <<< "$simOutput"; then
    exit 0
fi
exit 1
